// ==== logic/rs_types_pkg.sv ====
`default_nettype none

package rs_types_pkg;

    localparam int PC_W  = 32;  // Instruction address
    localparam int TAG_W = 8;   // Physical register tag
    localparam int OP_W  = 4;   // ALU opcode

    // Instruction as it leaves rename
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        logic [TAG_W-1:0] rd;
        logic [OP_W-1:0]  aluop;
        logic [TAG_W-1:0] src1;
        logic [TAG_W-1:0] src2;
        logic             src1_ready;
        logic             src2_ready;
    } dispatch_t;

    // Packet sent to the divider
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        logic [TAG_W-1:0] rd;
        logic [OP_W-1:0]  aluop;
        logic [TAG_W-1:0] src1;
        logic [TAG_W-1:0] src2;
    } issue_t;

endpackage

`default_nettype wire

// ==== logic/wakeup_pkg.sv ====
`default_nettype none

package wakeup_pkg;

    localparam int NUM_WAKE = 5;

    // Broadcast slots on the result bus
    localparam int WAKE_ALU    = 0;
    localparam int WAKE_MUL    = 1;
    localparam int WAKE_DIV    = 2;
    localparam int WAKE_LOAD   = 3;
    localparam int WAKE_BRANCH = 4;

    typedef struct packed {
        logic                           valid;
        logic [rs_types_pkg::TAG_W-1:0] tag;
    } wakeup_t;

    typedef wakeup_t [NUM_WAKE-1:0] wakeup_bus_t;

endpackage

`default_nettype wire

// ==== logic/rs_wakeup.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_wakeup #(
    parameter int RS_DEPTH = 16
) (
    input  wakeup_pkg::wakeup_bus_t                     wakeup,
    input  logic [RS_DEPTH*rs_types_pkg::TAG_W-1:0]     src1_tags,
    input  logic [RS_DEPTH*rs_types_pkg::TAG_W-1:0]     src2_tags,
    input  logic [rs_types_pkg::TAG_W-1:0]              dispatch_src1,
    input  logic [rs_types_pkg::TAG_W-1:0]              dispatch_src2,
    output logic [RS_DEPTH-1:0]                         wake1,
    output logic [RS_DEPTH-1:0]                         wake2,
    output logic                                        wake_in1,
    output logic                                        wake_in2
);
    import rs_types_pkg::*;
    import wakeup_pkg::*;

    // Any valid broadcast carrying this tag
    function automatic logic tag_hit(
        input logic [TAG_W-1:0] tag,
        input wakeup_bus_t      bus
    );
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_WAKE; w++) begin
            hit = hit | (bus[w].valid && (bus[w].tag == tag));
        end
        return hit;
    endfunction

    // Stored sources
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake1[i] = tag_hit(src1_tags[i*TAG_W +: TAG_W], wakeup);
            wake2[i] = tag_hit(src2_tags[i*TAG_W +: TAG_W], wakeup);
        end
    end

    // Instruction being dispatched this cycle
    assign wake_in1 = tag_hit(dispatch_src1, wakeup);
    assign wake_in2 = tag_hit(dispatch_src2, wakeup);

endmodule

`default_nettype wire

// ==== logic/rs_entry_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_entry_array #(
    parameter int RS_DEPTH = 16
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               dispatch_valid,
    input  rs_types_pkg::dispatch_t                            dispatch,
    input  logic [RS_DEPTH-1:0]                                wake1,
    input  logic [RS_DEPTH-1:0]                                wake2,
    input  logic                                               wake_in1,
    input  logic                                               wake_in2,
    input  logic                                               issue_fire,
    input  logic [$clog2(RS_DEPTH)-1:0]                        issue_idx,
    output logic [RS_DEPTH*rs_types_pkg::TAG_W-1:0]            src1_tags,
    output logic [RS_DEPTH*rs_types_pkg::TAG_W-1:0]            src2_tags,
    output logic [RS_DEPTH*$bits(rs_types_pkg::issue_t)-1:0]   entries,
    output logic [RS_DEPTH-1:0]                                entry_ready,
    output logic [$clog2(RS_DEPTH)-1:0]                        tail
);
    import rs_types_pkg::*;

    localparam int PKT_W = $bits(issue_t);

    issue_t              slots [RS_DEPTH];
    issue_t              in_pkt;
    logic [RS_DEPTH-1:0] ready1;
    logic [RS_DEPTH-1:0] ready2;
    logic [RS_DEPTH-1:0] busy;  // Slot holds a waiting instruction

    assign in_pkt = '{
        pc:    dispatch.pc,
        rd:    dispatch.rd,
        aluop: dispatch.aluop,
        src1:  dispatch.src1,
        src2:  dispatch.src2
    };

    // Packet storage
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            slots[tail] <= in_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready1 <= '0;
            ready2 <= '0;
            busy   <= '0;
            tail   <= '0;
        end else begin
            ready1 <= ready1 | wake1;
            ready2 <= ready2 | wake2;
            if (issue_fire) begin
                busy[issue_idx]   <= 1'b0;
                ready1[issue_idx] <= 1'b0;
                ready2[issue_idx] <= 1'b0;
            end
            // New entry wins over wakeup of the stale slot
            if (dispatch_valid) begin
                busy[tail]   <= 1'b1;
                ready1[tail] <= dispatch.src1_ready | wake_in1;
                ready2[tail] <= dispatch.src2_ready | wake_in2;
                tail         <= tail + 1'b1;  // Depth is a power of two
            end
        end
    end

    assign entry_ready = busy & ready1 & ready2;

    // Flat views for the wakeup and select logic
    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_flat
        assign src1_tags[g*TAG_W +: TAG_W] = slots[g].src1;
        assign src2_tags[g*TAG_W +: TAG_W] = slots[g].src2;
        assign entries[g*PKT_W +: PKT_W]   = slots[g];
    end

endmodule

`default_nettype wire

// ==== logic/rs_issue_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_issue_select #(
    parameter int RS_DEPTH     = 16,
    parameter int ISSUE_WINDOW = RS_DEPTH
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic [RS_DEPTH-1:0]                                entry_ready,
    input  logic [RS_DEPTH*$bits(rs_types_pkg::issue_t)-1:0]   entries,
    output logic                                               issue_fire,
    output logic [$clog2(RS_DEPTH)-1:0]                        issue_idx,
    output logic                                               issue_valid,
    output rs_types_pkg::issue_t                               issue
);
    import rs_types_pkg::*;

    localparam int PTR_W = $clog2(RS_DEPTH);
    localparam int PKT_W = $bits(issue_t);

    logic [PTR_W-1:0]    head;
    logic [RS_DEPTH-1:0] ahead;  // Issued before reaching the head
    logic                head_done;

    // Oldest ready entry in the window
    always_comb begin
        logic [PTR_W-1:0] slot;
        issue_fire = 1'b0;
        issue_idx  = head;
        // Walk from the far end so the nearest hit is kept
        for (int k = ISSUE_WINDOW - 1; k >= 0; k--) begin
            slot = head + PTR_W'(k);
            if (entry_ready[slot]) begin
                issue_fire = 1'b1;
                issue_idx  = slot;
            end
        end
    end

    // Head entry leaves now, or already left earlier
    assign head_done = (issue_fire && (issue_idx == head)) || ahead[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            ahead       <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire;
            if (issue_fire && (issue_idx != head)) begin
                ahead[issue_idx] <= 1'b1;
            end
            if (head_done) begin
                ahead[head] <= 1'b0;
                head        <= head + 1'b1;  // One step per cycle
            end
        end
    end

    // Divider payload
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue <= entries[issue_idx*PKT_W +: PKT_W];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_div.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_div #(
    parameter int RS_DEPTH     = 16,
    parameter int ISSUE_WINDOW = RS_DEPTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  rs_types_pkg::dispatch_t   dispatch,
    input  wakeup_pkg::wakeup_bus_t   wakeup,
    output logic                      issue_valid,
    output rs_types_pkg::issue_t      issue
);
    import rs_types_pkg::*;

    logic [RS_DEPTH-1:0]               wake1;
    logic [RS_DEPTH-1:0]               wake2;
    logic                              wake_in1;
    logic                              wake_in2;
    logic [RS_DEPTH*TAG_W-1:0]         src1_tags;
    logic [RS_DEPTH*TAG_W-1:0]         src2_tags;
    logic [RS_DEPTH*$bits(issue_t)-1:0] entries;
    logic [RS_DEPTH-1:0]               entry_ready;
    logic                              issue_fire;
    logic [$clog2(RS_DEPTH)-1:0]       issue_idx;

    rs_wakeup #(
        .RS_DEPTH(RS_DEPTH)
    ) wakeup_inst (
        .wakeup       (wakeup),
        .src1_tags    (src1_tags),
        .src2_tags    (src2_tags),
        .dispatch_src1(dispatch.src1),
        .dispatch_src2(dispatch.src2),
        .wake1        (wake1),
        .wake2        (wake2),
        .wake_in1     (wake_in1),
        .wake_in2     (wake_in2)
    );

    rs_entry_array #(
        .RS_DEPTH(RS_DEPTH)
    ) entry_array_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .wake1         (wake1),
        .wake2         (wake2),
        .wake_in1      (wake_in1),
        .wake_in2      (wake_in2),
        .issue_fire    (issue_fire),
        .issue_idx     (issue_idx),
        .src1_tags     (src1_tags),
        .src2_tags     (src2_tags),
        .entries       (entries),
        .entry_ready   (entry_ready),
        .tail          ()
    );

    rs_issue_select #(
        .RS_DEPTH    (RS_DEPTH),
        .ISSUE_WINDOW(ISSUE_WINDOW)
    ) issue_select_inst (
        .clk        (clk),
        .reset      (reset),
        .entry_ready(entry_ready),
        .entries    (entries),
        .issue_fire (issue_fire),
        .issue_idx  (issue_idx),
        .issue_valid(issue_valid),
        .issue      (issue)
    );

endmodule

`default_nettype wire

// ==== sim/rs_div_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_div_assert #(
    parameter int RS_DEPTH = 16
) (
    input logic                        clk,
    input logic                        reset,
    input logic                        issue_fire,
    input logic [$clog2(RS_DEPTH)-1:0] issue_idx,
    input logic [RS_DEPTH-1:0]         ahead,
    input logic                        issue_valid,
    input rs_types_pkg::issue_t        issue
);

    reset_clears_valid: assert property (@(posedge clk) reset |=> !issue_valid)
        else $error("issue_valid high in the cycle after reset");

    // Divider never sees X payload
    payload_known: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> !$isunknown(issue))
        else $error("issue payload unknown while issue_valid is high");

    // Slot issued ahead of the head is never picked again
    no_double_issue: assert property (@(posedge clk) disable iff (reset)
        issue_fire |-> !ahead[issue_idx])
        else $error("issued-ahead entry selected a second time");

endmodule

bind rs_issue_select rs_div_assert #(
    .RS_DEPTH(RS_DEPTH)
) rs_div_assert_inst (
    .clk        (clk),
    .reset      (reset),
    .issue_fire (issue_fire),
    .issue_idx  (issue_idx),
    .ahead      (ahead),
    .issue_valid(issue_valid),
    .issue      (issue)
);

`default_nettype wire

// ==== sim/rs_div_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_div_tb;
    import rs_types_pkg::*;
    import wakeup_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // About ten times the test length
    localparam int DRAIN_LIMIT    = 40;
    localparam int DEPTH          = 16;    // Default entry count of the DUT

    logic        clk;
    logic        reset;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    wakeup_bus_t wakeup;
    logic        issue_valid;
    issue_t      issue;

    issue_t exp_q[$];
    int     exp_cyc_q[$];  // Due cycle of each packet
    int     cycle = 0;
    int     errors = 0;
    int     test_errors = 0;
    int     tests_failed = 0;
    string  test_name = "startup";

    rs_div rs_div_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .wakeup        (wakeup),
        .issue_valid   (issue_valid),
        .issue         (issue)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Run stopped, no finish after %0d cycles", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    // Scoreboard, sampled mid-cycle
    always @(negedge clk) begin : monitor
        issue_t exp_pkt;
        int     exp_cyc;
        if (issue_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%s: unexpected issue of pc %h", test_name, issue.pc);
                note_error();
            end else begin
                exp_pkt = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                if (issue !== exp_pkt) begin
                    $display("ERR %s expected %h actual %h", test_name, exp_pkt, issue);
                    note_error();
                end
                if (cycle != exp_cyc) begin
                    $display("ERR %s issue cycle expected %0d actual %0d",
                             test_name, exp_cyc, cycle);
                    note_error();
                end
            end
        end
    end

    function automatic dispatch_t make_instr(input logic [TAG_W-1:0] rd, input logic [OP_W-1:0] op,
                                             input logic [TAG_W-1:0] s1, input logic [TAG_W-1:0] s2,
                                             input logic r1, input logic r2);
        dispatch_t d;
        d = '{pc: $urandom(), rd: rd, aluop: op, src1: s1, src2: s2, src1_ready: r1,
              src2_ready: r2};
        return d;
    endfunction

    task automatic expect_pkt(input dispatch_t d, input int cyc);
        issue_t p;
        p = '{pc: d.pc, rd: d.rd, aluop: d.aluop, src1: d.src1, src2: d.src2};
        exp_q.push_back(p);
        exp_cyc_q.push_back(cyc);
    endtask

    // Returns the cycle count at the capturing edge
    task automatic send(input dispatch_t d, output int cap);
        dispatch_valid = 1'b1;
        dispatch       = d;
        @(posedge clk);
        #1;
        cap            = cycle;
        dispatch_valid = 1'b0;
        wakeup         = '0;
    endtask

    task automatic broadcast(input int slot, input logic [TAG_W-1:0] tag, input logic valid);
        wakeup[slot].valid = valid;
        wakeup[slot].tag   = tag;
        @(posedge clk);
        #1;
        wakeup = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apply_reset(input int n);
        reset = 1'b1;
        idle(n);
        reset = 1'b0;
        if (issue_valid !== 1'b0) begin
            $display("%s: issue_valid not low after reset", test_name);
            note_error();
        end
    endtask

    task automatic wait_issued();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            idle(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected packets never issued", test_name, exp_q.size());
            note_error();
            exp_q.delete();
            exp_cyc_q.delete();
        end
        idle(3);  // Catches stray issues
    endtask

    task automatic finish_test();
        if (test_errors != 0) tests_failed++;
        $display("%s: %s, %0d errors", test_name, test_errors == 0 ? "ok" : "bad", test_errors);
        test_errors = 0;
    endtask

    task automatic test_in_order();
        dispatch_t d;
        int        cap;
        test_name = "in_order";
        for (int i = 0; i < 4; i++) begin
            d = make_instr(8'(8'h10 + i), 4'(i), 8'h01, 8'h02, 1'b1, 1'b1);
            send(d, cap);
            expect_pkt(d, cap + 1);
        end
        wait_issued();
        finish_test();
    endtask

    task automatic test_wakeup_sources();
        dispatch_t d;
        int        cap;
        test_name = "wakeup_sources";
        for (int w = 0; w < NUM_WAKE; w++) begin
            d = make_instr(8'(8'h40 + w), 4'h3, 8'(8'h20 + w), 8'h03, 1'b0, 1'b1);
            send(d, cap);
            idle(2);
            broadcast(w, d.src1, 1'b0);  // Invalid slot, no wakeup
            idle(2);
            expect_pkt(d, cycle + 2);
            broadcast(w, d.src1, 1'b1);
            wait_issued();
        end
        finish_test();
    endtask

    task automatic test_out_of_order();
        dispatch_t a;
        dispatch_t b;
        dispatch_t c;
        int        cap;
        test_name = "out_of_order";
        a = make_instr(8'h60, 4'h5, 8'h30, 8'h04, 1'b0, 1'b1);
        b = make_instr(8'h61, 4'h6, 8'h05, 8'h06, 1'b1, 1'b1);
        send(a, cap);
        send(b, cap);
        expect_pkt(b, cap + 1);
        wait_issued();
        expect_pkt(a, cycle + 2);
        broadcast(WAKE_MUL, 8'h30, 1'b1);
        wait_issued();
        // New head entry waits while younger ones wrap round to the skipped slot
        c = make_instr(8'h62, 4'h6, 8'h31, 8'h08, 1'b0, 1'b1);
        send(c, cap);
        for (int i = 0; i < DEPTH - 2; i++) begin
            b = make_instr(8'(8'h63 + i), 4'h6, 8'h07, 8'h08, 1'b1, 1'b1);
            send(b, cap);
            expect_pkt(b, cap + 1);
        end
        wait_issued();
        // Head entry wakes as the skipped slot refills, so it goes first
        b = make_instr(8'h7f, 4'h6, 8'h07, 8'h08, 1'b1, 1'b1);
        wakeup[WAKE_ALU].valid = 1'b1;
        wakeup[WAKE_ALU].tag   = 8'h31;
        send(b, cap);
        expect_pkt(c, cap + 1);
        expect_pkt(b, cap + 2);
        wait_issued();
        finish_test();
    endtask

    task automatic test_dispatch_capture();
        dispatch_t d;
        int        cap;
        test_name = "dispatch_capture";
        d = make_instr(8'h70, 4'h7, 8'h36, 8'h37, 1'b0, 1'b0);
        wakeup[WAKE_ALU].valid    = 1'b1;
        wakeup[WAKE_ALU].tag      = 8'h36;
        wakeup[WAKE_BRANCH].valid = 1'b1;
        wakeup[WAKE_BRANCH].tag   = 8'h37;
        send(d, cap);
        expect_pkt(d, cap + 1);
        wait_issued();
        finish_test();
    endtask

    task automatic test_reset_discard();
        dispatch_t a;
        dispatch_t b;
        int        cap;
        test_name = "reset_discard";
        a = make_instr(8'h80, 4'h8, 8'h50, 8'h09, 1'b0, 1'b1);
        b = make_instr(8'h81, 4'h9, 8'h09, 8'h51, 1'b1, 1'b0);
        send(a, cap);
        send(b, cap);
        apply_reset(4);
        broadcast(WAKE_LOAD, 8'h50, 1'b1);
        broadcast(WAKE_DIV, 8'h51, 1'b1);
        idle(4);
        if (issue_valid !== 1'b0) begin
            $display("%s: issue_valid high with no entries left", test_name);
            note_error();
        end
        finish_test();
    endtask

    initial begin
        void'($urandom(32'h12ea_23b2));
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        wakeup         = '0;
        apply_reset(16);
        test_in_order();
        test_wakeup_sources();
        test_out_of_order();
        test_dispatch_capture();
        test_reset_discard();
        $display("Tests 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/rs_types_pkg.sv
logic/wakeup_pkg.sv
logic/rs_wakeup.sv
logic/rs_entry_array.sv
logic/rs_issue_select.sv
logic/rs_div.sv
sim/rs_div_assert.sv
sim/rs_div_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rs_div_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(wildcard logic/*.sv sim/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
